// ==== logic/imuldiv_div_iterative.sv ====
// iterative restoring divider, signed and unsigned
// 32 trial-subtract steps then one sign correction cycle

module imuldiv_div_iterative (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit port
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_fix,
    st_done
  } state_e;

  state_e                          state;
  logic [4:0]                      step;
  logic                            accept;
  logic                            resp_fire;
  logic                            req_signed;

  // datapath registers
  imuldiv_pkg::muldiv_fn_e         fn_q;
  logic                            sign_a;
  logic                            sign_b;
  logic                            div_zero;
  logic [imuldiv_pkg::xlen-1:0]    rem;
  logic [imuldiv_pkg::xlen-1:0]    quo;
  logic [imuldiv_pkg::xlen-1:0]    dsor;

  // step arithmetic, one bit wider than a word
  logic [imuldiv_pkg::xlen:0]      trial;
  logic [imuldiv_pkg::xlen:0]      trial_sub;
  logic                            fits;
  logic                            fix_signed;

  assign accept     = port.req_val && port.req_rdy;
  assign resp_fire  = port.resp_val && port.resp_rdy;
  assign req_signed = (port.req_fn == imuldiv_pkg::fn_div);

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      step  <= 5'd0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_calc;
            step  <= 5'd0;
          end
        end
        st_calc: begin
          step <= step + 5'd1;
          if (step == 5'd31) begin
            state <= st_fix;
          end
        end
        // single cycle, apply signs
        st_fix: state <= st_done;
        st_done: begin
          if (resp_fire) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  // shift next dividend bit into the partial remainder
  assign trial     = {rem, quo[imuldiv_pkg::xlen-1]};
  assign trial_sub = trial - {1'b0, dsor};
  assign fits      = (trial >= {1'b0, dsor});

  assign fix_signed = (fn_q == imuldiv_pkg::fn_div);

  always_ff @(posedge clk) begin
    if (accept) begin
      fn_q     <= port.req_fn;
      sign_a   <= port.req_a[imuldiv_pkg::xlen-1];
      sign_b   <= port.req_b[imuldiv_pkg::xlen-1];
      div_zero <= (port.req_b == '0);
      rem      <= '0;
      // quo starts as dividend magnitude, bits shift out as quotient shifts in
      if (req_signed) begin
        quo  <= port.req_a[imuldiv_pkg::xlen-1] ? -port.req_a : port.req_a;
        dsor <= port.req_b[imuldiv_pkg::xlen-1] ? -port.req_b : port.req_b;
      end else begin
        quo  <= port.req_a;
        dsor <= port.req_b;
      end
    end else if (state == st_calc) begin
      // restore by keeping the unsubtracted value
      rem <= fits ? trial_sub[imuldiv_pkg::xlen-1:0] : trial[imuldiv_pkg::xlen-1:0];
      quo <= {quo[imuldiv_pkg::xlen-2:0], fits};
    end else if (state == st_fix) begin
      // zero divisor gives all ones, remainder stays the dividend
      if (div_zero) begin
        quo <= '1;
      end else if (fix_signed && (sign_a ^ sign_b)) begin
        quo <= -quo;
      end
      // remainder follows dividend sign
      if (fix_signed && sign_a) begin
        rem <= -rem;
      end
    end
  end

  assign port.req_rdy     = (state == st_idle);
  assign port.resp_val    = (state == st_done);
  assign port.resp_result = {rem, quo};

endmodule

// ==== logic/imuldiv_mul_iterative.sv ====
// iterative signed multiplier
// shift-and-add over operand magnitudes, sign applied on the way out

module imuldiv_mul_iterative (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.unit port
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_e;

  state_e                                 state;
  logic [4:0]                             step;
  logic                                   accept;
  logic                                   resp_fire;

  // datapath registers
  logic [imuldiv_pkg::result_width-1:0]   mcand;
  logic [imuldiv_pkg::result_width-1:0]   acc;
  logic [imuldiv_pkg::xlen-1:0]           mplier;
  logic                                   neg;

  // operand magnitudes
  logic [imuldiv_pkg::xlen-1:0]           a_mag;
  logic [imuldiv_pkg::xlen-1:0]           b_mag;

  assign accept    = port.req_val && port.req_rdy;
  assign resp_fire = port.resp_val && port.resp_rdy;

  // most-negative input maps to 2^31, which still fits unsigned
  assign a_mag = port.req_a[imuldiv_pkg::xlen-1] ? -port.req_a : port.req_a;
  assign b_mag = port.req_b[imuldiv_pkg::xlen-1] ? -port.req_b : port.req_b;

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      step  <= 5'd0;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_calc;
            step  <= 5'd0;
          end
        end
        st_calc: begin
          // 32 steps, counter wraps back to zero on the last one
          step <= step + 5'd1;
          if (step == 5'd31) begin
            state <= st_done;
          end
        end
        st_done: begin
          // hold result until the consumer takes it
          if (resp_fire) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{imuldiv_pkg::xlen{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg    <= port.req_a[imuldiv_pkg::xlen-1] ^ port.req_b[imuldiv_pkg::xlen-1];
    end else if (state == st_calc) begin
      // add shifted multiplicand when multiplier lsb set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign port.req_rdy     = (state == st_idle);
  assign port.resp_val    = (state == st_done);
  // product sign from operand signs
  assign port.resp_result = neg ? -acc : acc;

endmodule

// ==== logic/imuldiv_order_keeper.sv ====
// request steering and in-order response merge
// one-bit unit tag per outstanding request, head tag picks the response

module imuldiv_order_keeper (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  imuldiv_pkg::muldiv_fn_e               req_fn,
  input  logic [imuldiv_pkg::xlen-1:0]          req_a,
  input  logic [imuldiv_pkg::xlen-1:0]          req_b,
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output logic [imuldiv_pkg::result_width-1:0]  resp_result,
  imuldiv_unit_if.steer                         mul_port,
  imuldiv_unit_if.steer                         div_port
);

  localparam int ptr_w = imuldiv_pkg::order_ptr_width;

  // tag 0 is the multiplier, tag 1 the divider
  logic                tag_q [imuldiv_pkg::order_depth];
  logic [ptr_w-1:0]    head_ptr;
  logic [ptr_w-1:0]    tail_ptr;
  logic [ptr_w:0]      count;
  logic                full;
  logic                empty;
  logic                head_tag;
  logic                req_is_div;
  logic                push;
  logic                pop;

  assign full  = (count == (ptr_w + 1)'(imuldiv_pkg::order_depth));
  assign empty = (count == '0);

  // ----------------------------------------------------------------------
  // request steering
  // ----------------------------------------------------------------------

  assign req_is_div = (req_fn != imuldiv_pkg::fn_mul);

  // operands go to both units, only one sees valid
  assign mul_port.req_val = req_val && !req_is_div && !full;
  assign div_port.req_val = req_val && req_is_div && !full;
  assign mul_port.req_fn  = req_fn;
  assign div_port.req_fn  = req_fn;
  assign mul_port.req_a   = req_a;
  assign div_port.req_a   = req_a;
  assign mul_port.req_b   = req_b;
  assign div_port.req_b   = req_b;

  assign req_rdy = (req_is_div ? div_port.req_rdy : mul_port.req_rdy) && !full;
  assign push    = req_val && req_rdy;

  // ----------------------------------------------------------------------
  // response merge
  // ----------------------------------------------------------------------

  assign head_tag = tag_q[head_ptr];

  // non-head unit waits with its result until it reaches the head
  assign resp_val    = !empty && (head_tag ? div_port.resp_val : mul_port.resp_val);
  assign resp_result = head_tag ? div_port.resp_result : mul_port.resp_result;

  assign mul_port.resp_rdy = resp_rdy && !empty && !head_tag;
  assign div_port.resp_rdy = resp_rdy && !empty && head_tag;

  assign pop = resp_val && resp_rdy;

  // ----------------------------------------------------------------------
  // tag queue
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[tail_ptr] <= req_is_div;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
      if (pop) begin
        head_ptr <= head_ptr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== logic/imuldiv_pkg.sv ====
// multiply/divide unit shared definitions
// widths, function codes and order queue sizing

package imuldiv_pkg;

  // ----------------------------------------------------------------------
  // data widths
  // ----------------------------------------------------------------------

  // operand width, one processor word
  localparam int xlen = 32;

  // response word
  // mul returns the full signed 64-bit product
  // div/divu pack remainder in [63:32] and quotient in [31:0]
  localparam int result_width = 64;

  // ----------------------------------------------------------------------
  // function codes
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_e;

  // ----------------------------------------------------------------------
  // order keeper sizing
  // ----------------------------------------------------------------------

  // max requests in flight across both units
  localparam int order_depth = 4;

  // queue pointer width, depth is a power of two so pointers wrap freely
  localparam int order_ptr_width = $clog2(order_depth);

endpackage

// ==== logic/imuldiv_top.sv ====
// integer multiply/divide unit top level
// multiplier and divider side by side behind an order keeper

module imuldiv_top (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  imuldiv_pkg::muldiv_fn_e               req_fn,
  input  logic [imuldiv_pkg::xlen-1:0]          req_a,
  input  logic [imuldiv_pkg::xlen-1:0]          req_b,
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output logic [imuldiv_pkg::result_width-1:0]  resp_result
);

  // one channel pair per unit
  imuldiv_unit_if mul_if ();
  imuldiv_unit_if div_if ();

  imuldiv_mul_iterative mul0 (
    .clk   (clk),
    .reset (reset),
    .port  (mul_if.unit)
  );

  imuldiv_div_iterative div0 (
    .clk   (clk),
    .reset (reset),
    .port  (div_if.unit)
  );

  // steering and reordering
  imuldiv_order_keeper order0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .mul_port    (mul_if.steer),
    .div_port    (div_if.steer)
  );

endmodule

// ==== logic/imuldiv_unit_if.sv ====
// request/response channel pair for one arithmetic unit
// valid/ready on both directions

interface imuldiv_unit_if;

  // request channel, steering side to unit
  logic                                   req_val;
  logic                                   req_rdy;
  imuldiv_pkg::muldiv_fn_e                req_fn;
  logic [imuldiv_pkg::xlen-1:0]           req_a;
  logic [imuldiv_pkg::xlen-1:0]           req_b;

  // response channel, unit back to steering side
  logic                                   resp_val;
  logic                                   resp_rdy;
  logic [imuldiv_pkg::result_width-1:0]   resp_result;

  // arithmetic unit end
  modport unit (
    input  req_val, req_fn, req_a, req_b, resp_rdy,
    output req_rdy, resp_val, resp_result
  );

  // order keeper end
  modport steer (
    output req_val, req_fn, req_a, req_b, resp_rdy,
    input  req_rdy, resp_val, resp_result
  );

endinterface

// ==== project.f ====
logic/imuldiv_pkg.sv
logic/imuldiv_unit_if.sv
logic/imuldiv_mul_iterative.sv
logic/imuldiv_div_iterative.sv
logic/imuldiv_order_keeper.sv
logic/imuldiv_top.sv
testbench/tb_clock_gen.sv
testbench/imuldiv_tb.sv

// ==== testbench/imuldiv_tb.sv ====
// testbench for the multiply/divide unit
// random requests checked in order against a reference model

module imuldiv_tb;

  localparam int n_mul    = 200;
  localparam int n_div    = 100;
  localparam int n_corner = 8;
  localparam int n_mix    = 200;
  localparam int total_reqs = n_mul + n_div + n_corner + n_mix;
  // worst unit latency per request times slack for back-pressure
  localparam int timeout_cycles = total_reqs * 34 * 4 + 20;

  logic                                   clk;
  logic                                   reset;
  logic                                   req_val;
  logic                                   req_rdy;
  imuldiv_pkg::muldiv_fn_e                req_fn;
  logic [31:0]                            req_a;
  logic [31:0]                            req_b;
  logic                                   resp_val;
  logic                                   resp_rdy;
  logic [63:0]                            resp_result;

  integer      seed = 32'hfa64bce5;
  logic [63:0] exp_q [$];
  int          req_transfers = 0;
  int          resp_transfers = 0;
  int          checks = 0;
  int          errors = 0;
  logic        heavy_bp = 1'b0;

  tb_clock_gen clock0 (.clk(clk), .reset(reset));

  imuldiv_top dut0 (.*);

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------

  // remainder in the upper half, quotient in the lower half for divides
  function automatic logic [63:0] expected_result(input imuldiv_pkg::muldiv_fn_e fn,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    longint sa;
    longint sb;
    longint q;
    longint r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (fn == imuldiv_pkg::fn_mul) begin
      return sa * sb;
    end
    if (b == 32'h0) begin
      return {a, 32'hffffffff};
    end
    if (fn == imuldiv_pkg::fn_divu) begin
      return {a % b, a / b};
    end
    // 64-bit math keeps most-negative / -1 from overflowing
    q = sa / sb;
    r = sa % sb;
    return {r[31:0], q[31:0]};
  endfunction

  // corner values show up about half the time
  function automatic logic [31:0] draw_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0: return 32'h00000000;
      3'd1: return 32'h00000001;
      3'd2: return 32'hffffffff;
      3'd3: return 32'h80000000;
      default: return $random(seed);
    endcase
  endfunction

  // hold the request until it transfers, caller stays one unit past the edge
  task automatic send_req(input imuldiv_pkg::muldiv_fn_e fn, input logic [31:0] a,
                          input logic [31:0] b);
    logic taken;
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    taken   = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_rdy;
      @(posedge clk);
      #1;
    end
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(input string name, input int checks_before,
                             input int errors_before);
    $display("%s: %0d checks, %0d errors", name, checks - checks_before,
             errors - errors_before);
  endtask

  // ----------------------------------------------------------------------
  // monitor, sampled mid-cycle where everything is settled
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    logic [63:0] expected;
    if (!reset && req_val && req_rdy) begin
      exp_q.push_back(expected_result(req_fn, req_a, req_b));
      req_transfers++;
    end
    if (!reset && resp_val && resp_rdy) begin
      resp_transfers++;
      checks++;
      assert (exp_q.size() != 0) else begin
        $display("response arrived with no request outstanding");
        errors++;
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        assert (resp_result === expected) else begin
          $display("FAILED resp_result: got %h expected %h", resp_result, expected);
          errors++;
        end
      end
    end
  end

  // random back-pressure, drawn a little after the stimulus
  always @(posedge clk) begin
    #2;
    if (reset) begin
      resp_rdy = 1'b0;
    end else if (heavy_bp) begin
      resp_rdy = $random(seed) & 1;
    end else begin
      resp_rdy = ($random(seed) & 3) != 0;
    end
  end

  // watchdog
  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: responses stopped after %0d cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    int c0;
    int e0;
    logic [31:0] shift;
    logic [31:0] pick;
    req_val  = 1'b0;
    req_fn   = imuldiv_pkg::fn_mul;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;

    // reset state, two cycles in reset and the first one after
    c0 = checks;
    e0 = errors;
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (!resp_val && req_rdy) else begin
        $display("FAILED resp_val/req_rdy after reset: %h/%h", resp_val, req_rdy);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    report_test("reset state", c0, e0);

    c0 = checks;
    e0 = errors;
    repeat (n_mul) send_req(imuldiv_pkg::fn_mul, draw_operand(), draw_operand());
    wait_drain();
    report_test("signed multiply", c0, e0);

    // smaller divisors give quotients with more set bits
    c0 = checks;
    e0 = errors;
    repeat (n_div) begin
      shift = $random(seed);
      pick  = $random(seed);
      send_req(pick[0] ? imuldiv_pkg::fn_divu : imuldiv_pkg::fn_div, draw_operand(),
               draw_operand() >> shift[4:0]);
    end
    wait_drain();
    report_test("signed and unsigned divide", c0, e0);

    c0 = checks;
    e0 = errors;
    send_req(imuldiv_pkg::fn_div, 32'h12345678, 32'h00000000);
    send_req(imuldiv_pkg::fn_div, 32'h87654321, 32'h00000000);
    send_req(imuldiv_pkg::fn_divu, 32'h87654321, 32'h00000000);
    send_req(imuldiv_pkg::fn_div, 32'h00000000, 32'h00000000);
    send_req(imuldiv_pkg::fn_div, 32'h80000000, 32'hffffffff);
    send_req(imuldiv_pkg::fn_divu, 32'h80000000, 32'hffffffff);
    send_req(imuldiv_pkg::fn_div, 32'h80000000, 32'h00000001);
    send_req(imuldiv_pkg::fn_div, 32'hfffffff9, 32'h00000002);
    wait_drain();
    report_test("division corners", c0, e0);

    // mixed traffic keeps both units busy, heavier back-pressure
    c0 = checks;
    e0 = errors;
    heavy_bp = 1'b1;
    repeat (n_mix) begin
      pick = $unsigned($random(seed)) % 3;
      send_req(imuldiv_pkg::muldiv_fn_e'(pick[1:0]), draw_operand(), draw_operand());
    end
    wait_drain();
    checks++;
    assert (exp_q.size() == 0 && resp_transfers == req_transfers) else begin
      $display("responses lost or duplicated, %0d requests, %0d responses",
               req_transfers, resp_transfers);
      errors++;
    end
    report_test("ordering and back-pressure", c0, e0);

    $display("totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// testbench clock and reset source
// 8-unit clock period, reset held high for the first 3 rising edges

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // release lands just after the third edge, in step with the stimulus
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule
